//--- design/conv_pe_config.svh
`ifndef CONV_PE_CONFIG_SVH
`define CONV_PE_CONFIG_SVH

// Sample width, shared by IF and filter data
`define CONV_DATA_W 8

// Partial sum width
`define CONV_ACC_W 24

// IF scratchpad
`define CONV_IF_DEPTH 64
`define CONV_IF_AW 6

// Filter scratchpad
`define CONV_FILT_DEPTH 16
`define CONV_FILT_AW 4

// APB register address width
`define CONV_APB_AW 4

`endif

//--- design/conv_pe_data_pkg.sv
`default_nettype none

`include "conv_pe_config.svh"

package conv_pe_data_pkg;

    // Word popped from the IF buffer
    typedef struct packed {
        logic                    last;
        logic [`CONV_DATA_W-1:0] data;
    } if_word_t;

    typedef struct packed {
        logic [`CONV_DATA_W-1:0] data;
    } filt_word_t;

    // Scratchpad write port, sized for the IF side
    typedef struct packed {
        logic                    we;
        logic [`CONV_IF_AW-1:0]  addr;
        logic [`CONV_DATA_W-1:0] data;
    } scratch_wr_t;

    typedef struct packed {
        logic [`CONV_ACC_W-1:0] value;
    } psum_t;

endpackage

`default_nettype wire

//--- design/conv_pe_ctrl_pkg.sv
`default_nettype none

`include "conv_pe_config.svh"

package conv_pe_ctrl_pkg;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [`CONV_APB_AW-1:0] paddr;
        logic [31:0]            pwdata;
    } apb_req_t;

    typedef enum logic [`CONV_APB_AW-1:0] {
        REG_CTRL     = 4'h0,
        REG_FILT_LEN = 4'h4,
        REG_STRIDE   = 4'h8,
        REG_STATUS   = 4'hC
    } apb_reg_e;

    typedef enum logic [2:0] {
        SEQ_IDLE,
        SEQ_LOAD,
        SEQ_RUN,
        SEQ_DRAIN,
        SEQ_DONE
    } seq_state_e;

    typedef struct packed {
        logic [`CONV_FILT_AW:0]  filt_len;
        logic [`CONV_IF_AW-1:0]  stride;
    } pe_cfg_t;

    typedef struct packed {
        logic                  busy;
        logic                  done;
        logic [`CONV_IF_AW:0]  out_count;
    } pe_status_t;

endpackage

`default_nettype wire

//--- design/conv_pe_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_pe_config.svh"

module conv_pe_regs
    import conv_pe_ctrl_pkg::*;
(
    input  wire apb_req_t           apb_req,
    input  wire                     clk,
    input  wire                     rst,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    input  wire                     seq_done,
    input  wire [`CONV_IF_AW:0]     out_count,
    output pe_cfg_t                 cfg,
    output logic                    start
);

    logic       access;
    logic       wr_access;
    logic       wr_ok;
    logic       start_req;
    logic       busy;
    logic       done;
    pe_status_t status;

    assign access    = apb_req.psel & apb_req.penable;
    assign wr_access = access & apb_req.pwrite;
    assign pready    = 1'b1;

    // Config registers are locked while a run is in progress
    always_comb begin
        case (apb_req.paddr)
            REG_CTRL:                 wr_ok = 1'b1;
            REG_FILT_LEN, REG_STRIDE: wr_ok = ~busy;
            default:                  wr_ok = 1'b0;
        endcase
    end

    assign pslverr   = wr_access & ~wr_ok;
    assign start_req = wr_access & (apb_req.paddr == REG_CTRL) & apb_req.pwdata[0] & ~busy;

    assign status = '{busy: busy, done: done, out_count: out_count};

    always_comb begin
        prdata = '0;
        if (apb_req.psel && !apb_req.pwrite) begin
            case (apb_req.paddr)
                REG_CTRL:     prdata = 32'(busy);
                REG_FILT_LEN: prdata = 32'(cfg.filt_len);
                REG_STRIDE:   prdata = 32'(cfg.stride);
                REG_STATUS:   prdata = 32'(status);
                default:      prdata = '0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cfg   <= '{filt_len: 5'd1, stride: 6'd1};
            start <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
        end else begin
            start <= start_req;
            if (start_req) begin
                busy <= 1'b1;
                done <= 1'b0;
            end else if (seq_done) begin
                busy <= 1'b0;
                done <= 1'b1;
            end
            if (wr_access && !busy) begin
                case (apb_req.paddr)
                    REG_FILT_LEN: cfg.filt_len <= apb_req.pwdata[`CONV_FILT_AW:0];
                    REG_STRIDE:   cfg.stride   <= apb_req.pwdata[`CONV_IF_AW-1:0];
                    default:      ;
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- design/if_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_pe_config.svh"

module if_loader
    import conv_pe_data_pkg::*;
    import conv_pe_ctrl_pkg::*;
(
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 start,
    input  wire                 if_buf_empty,
    input  wire if_word_t       if_buf_data,
    output logic                if_buf_read,
    output scratch_wr_t         if_wr,
    output logic [`CONV_IF_AW:0] if_count,
    output logic                if_valid
);

    localparam int CNT_W = `CONV_IF_AW + 1;

    seq_state_e       state;
    logic [CNT_W-1:0] count;
    logic             full;

    assign full        = (count == CNT_W'(`CONV_IF_DEPTH));
    assign if_buf_read = (state == SEQ_LOAD) & ~if_buf_empty & ~full;

    // Word count doubles as the write address
    assign if_wr    = '{we: if_buf_read, addr: count[`CONV_IF_AW-1:0], data: if_buf_data.data};
    assign if_count = count;
    assign if_valid = (state == SEQ_DONE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= SEQ_IDLE;
            count <= '0;
        end else if (start) begin
            state <= SEQ_LOAD;
            count <= '0;
        end else if (if_buf_read) begin
            count <= count + 1'b1;
            // Stop on the flagged word or on the last free entry
            if (if_buf_data.last || count == CNT_W'(`CONV_IF_DEPTH - 1)) begin
                state <= SEQ_DONE;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/filt_loader.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_pe_config.svh"

module filt_loader
    import conv_pe_data_pkg::*;
(
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    start,
    input  wire [`CONV_FILT_AW:0]  filt_len,
    input  wire                    filt_buf_empty,
    input  wire filt_word_t        filt_buf_data,
    output logic                   filt_buf_read,
    output scratch_wr_t            filt_wr,
    output logic                   filt_ready
);

    localparam int CNT_W = `CONV_FILT_AW + 1;

    logic [CNT_W-1:0] count;
    logic             loading;
    logic             full;

    assign full          = (count == CNT_W'(`CONV_FILT_DEPTH));
    assign filt_buf_read = loading & ~filt_buf_empty & ~full;
    assign filt_wr = '{
        we:   filt_buf_read,
        addr: {{(`CONV_IF_AW - `CONV_FILT_AW){1'b0}}, count[`CONV_FILT_AW-1:0]},
        data: filt_buf_data.data
    };

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            loading    <= 1'b0;
            filt_ready <= 1'b0;
        end else if (start) begin
            count      <= '0;
            loading    <= (filt_len != '0);
            filt_ready <= (filt_len == '0);
        end else if (filt_buf_read) begin
            count <= count + 1'b1;
            if (count + 1'b1 == filt_len || count == CNT_W'(`CONV_FILT_DEPTH - 1)) begin
                loading    <= 1'b0;
                filt_ready <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mac_datapath.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_pe_config.svh"

module mac_datapath
    import conv_pe_data_pkg::*;
    import conv_pe_ctrl_pkg::*;
(
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start,
    input  wire pe_cfg_t         cfg,
    input  wire scratch_wr_t     if_wr,
    input  wire scratch_wr_t     filt_wr,
    input  wire [`CONV_IF_AW:0]  if_count,
    input  wire                  if_valid,
    input  wire                  filt_ready,
    input  wire                  stall,
    output psum_t                psum,
    output logic                 psum_valid,
    output logic [`CONV_IF_AW:0] out_count,
    output logic                 seq_done
);

    localparam int PROD_W = 2 * `CONV_DATA_W;

    logic [`CONV_DATA_W-1:0] if_mem   [`CONV_IF_DEPTH];
    logic [`CONV_DATA_W-1:0] filt_mem [`CONV_FILT_DEPTH];

    seq_state_e               state;
    logic [`CONV_IF_AW:0]     base;
    logic [`CONV_FILT_AW-1:0] tap;
    logic [`CONV_IF_AW+1:0]   next_base;
    logic [`CONV_IF_AW+1:0]   next_end;
    logic [`CONV_IF_AW-1:0]   if_raddr;
    logic                     first_fits;
    logic                     next_fits;
    logic                     tap_last;
    logic                     issue;

    logic                     s1_valid, s1_first, s1_last, s1_final;
    logic                     s2_valid, s2_first, s2_last, s2_final;
    logic [`CONV_DATA_W-1:0]  if_q;
    logic [`CONV_DATA_W-1:0]  filt_q;
    logic [PROD_W-1:0]        prod_q;
    logic [`CONV_ACC_W-1:0]   acc;
    logic [`CONV_ACC_W-1:0]   acc_sum;

    always_ff @(posedge clk) begin
        if (if_wr.we) begin
            if_mem[if_wr.addr] <= if_wr.data;
        end
        if (filt_wr.we) begin
            filt_mem[filt_wr.addr[`CONV_FILT_AW-1:0]] <= filt_wr.data;
        end
    end

    // Window fits while base + filter length <= IF count
    assign next_base  = {1'b0, base} + {2'b0, cfg.stride};
    assign next_end   = next_base + {2'b0, cfg.filt_len};
    assign next_fits  = (next_end <= {1'b0, if_count});
    assign first_fits = ({1'b0, cfg.filt_len} <= if_count);
    assign tap_last   = ({1'b0, tap} == cfg.filt_len - 1'b1);
    assign if_raddr   = base[`CONV_IF_AW-1:0] + {{(`CONV_IF_AW - `CONV_FILT_AW){1'b0}}, tap};
    assign issue      = (state == SEQ_RUN) & ~stall;

    always_ff @(posedge clk) begin
        if (rst || start) begin
            state     <= rst ? SEQ_IDLE : SEQ_LOAD;
            base      <= '0;
            tap       <= '0;
            out_count <= '0;
        end else begin
            case (state)
                SEQ_LOAD: begin
                    if (if_valid && filt_ready) begin
                        state <= first_fits ? SEQ_RUN : SEQ_DONE;
                    end
                end
                SEQ_RUN: begin
                    if (!stall) begin
                        if (tap == '0) begin
                            out_count <= out_count + 1'b1;
                        end
                        if (tap_last) begin
                            tap <= '0;
                            if (next_fits) begin
                                base <= next_base[`CONV_IF_AW:0];
                            end else begin
                                state <= SEQ_DRAIN;
                            end
                        end else begin
                            tap <= tap + 1'b1;
                        end
                    end
                end
                SEQ_DRAIN: begin
                    if (seq_done) begin
                        state <= SEQ_DONE;
                    end
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst || start) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else if (!stall) begin
            s1_valid <= issue;
            s2_valid <= s1_valid;
        end
    end

    // Read, multiply and accumulate stages, frozen together on stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            if_q     <= if_mem[if_raddr];
            filt_q   <= filt_mem[tap];
            s1_first <= (tap == '0);
            s1_last  <= tap_last;
            s1_final <= tap_last & ~next_fits;
            prod_q   <= if_q * filt_q;
            s2_first <= s1_first;
            s2_last  <= s1_last;
            s2_final <= s1_final;
            if (s2_valid) begin
                acc <= acc_sum;
            end
        end
    end

    // Accumulator restarts at the first tap of each window
    assign acc_sum = (s2_first ? '0 : acc) + {{(`CONV_ACC_W - PROD_W){1'b0}}, prod_q};

    assign psum       = '{value: acc_sum};
    assign psum_valid = s2_valid & s2_last;

    // Also ends a run that has no complete window
    assign seq_done = (psum_valid & ~stall & s2_final) |
                      ((state == SEQ_LOAD) & if_valid & filt_ready & ~first_fits);

endmodule

`default_nettype wire

//--- design/psum_writer.sv
`timescale 1ns/10ps
`default_nettype none

module psum_writer
    import conv_pe_data_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire psum_t psum,
    input  wire        psum_valid,
    input  wire        out_buf_full,
    output logic       out_buf_write,
    output psum_t      out_buf_data,
    output logic       stall
);

    logic  held;
    psum_t held_sum;

    // Held sum has priority, new sums pass straight through
    assign out_buf_write = held ? ~out_buf_full : (psum_valid & ~out_buf_full);
    assign out_buf_data  = held ? held_sum : psum;
    assign stall         = held;

    always_ff @(posedge clk) begin
        if (rst) begin
            held <= 1'b0;
        end else if (held) begin
            if (!out_buf_full) begin
                held <= 1'b0;
            end
        end else if (psum_valid && out_buf_full) begin
            held <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!held && psum_valid) begin
            held_sum <= psum;
        end
    end

endmodule

`default_nettype wire

//--- design/conv_pe_top.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_pe_config.svh"

module conv_pe_top
    import conv_pe_data_pkg::*;
    import conv_pe_ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             rst,
    input  wire apb_req_t   apb_req,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr,
    input  wire             if_buf_empty,
    input  wire if_word_t   if_buf_data,
    output logic            if_buf_read,
    input  wire             filt_buf_empty,
    input  wire filt_word_t filt_buf_data,
    output logic            filt_buf_read,
    input  wire             out_buf_full,
    output logic            out_buf_write,
    output psum_t           out_buf_data
);

    pe_cfg_t              cfg;
    logic                 start;
    logic                 seq_done;
    logic [`CONV_IF_AW:0] out_count;
    logic [`CONV_IF_AW:0] if_count;
    logic                 if_valid;
    logic                 filt_ready;
    scratch_wr_t          if_wr;
    scratch_wr_t          filt_wr;
    psum_t                psum;
    logic                 psum_valid;
    logic                 stall;

    conv_pe_regs i_regs (
        .clk       (clk),
        .rst       (rst),
        .apb_req   (apb_req),
        .prdata    (prdata),
        .pready    (pready),
        .pslverr   (pslverr),
        .seq_done  (seq_done),
        .out_count (out_count),
        .cfg       (cfg),
        .start     (start)
    );

    if_loader i_if_loader (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .if_buf_empty (if_buf_empty),
        .if_buf_data  (if_buf_data),
        .if_buf_read  (if_buf_read),
        .if_wr        (if_wr),
        .if_count     (if_count),
        .if_valid     (if_valid)
    );

    filt_loader i_filt_loader (
        .clk            (clk),
        .rst            (rst),
        .start          (start),
        .filt_len       (cfg.filt_len),
        .filt_buf_empty (filt_buf_empty),
        .filt_buf_data  (filt_buf_data),
        .filt_buf_read  (filt_buf_read),
        .filt_wr        (filt_wr),
        .filt_ready     (filt_ready)
    );

    mac_datapath i_datapath (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .cfg        (cfg),
        .if_wr      (if_wr),
        .filt_wr    (filt_wr),
        .if_count   (if_count),
        .if_valid   (if_valid),
        .filt_ready (filt_ready),
        .stall      (stall),
        .psum       (psum),
        .psum_valid (psum_valid),
        .out_count  (out_count),
        .seq_done   (seq_done)
    );

    psum_writer i_writer (
        .clk           (clk),
        .rst           (rst),
        .psum          (psum),
        .psum_valid    (psum_valid),
        .out_buf_full  (out_buf_full),
        .out_buf_write (out_buf_write),
        .out_buf_data  (out_buf_data),
        .stall         (stall)
    );

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset released on a rising edge
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

//--- sim/tb_conv_pe.sv
`timescale 1ns/10ps
`default_nettype none

`include "conv_pe_config.svh"

module tb_conv_pe
    import conv_pe_data_pkg::*;
    import conv_pe_ctrl_pkg::*;
();

    localparam int DONE_POLLS = 300;
    localparam int OUT_WAIT   = 200;

    logic                   clk;
    logic                   rst;
    apb_req_t               apb_req = '0;
    logic [31:0]            prdata;
    logic                   pready;
    logic                   pslverr;
    logic                   if_buf_empty = 1'b1;
    if_word_t               if_buf_data = '0;
    logic                   if_buf_read;
    logic                   filt_buf_empty = 1'b1;
    filt_word_t             filt_buf_data = '0;
    logic                   filt_buf_read;
    logic                   out_buf_full = 1'b0;
    logic                   out_buf_write;
    psum_t                  out_buf_data;

    if_word_t               if_fifo[$];
    filt_word_t             filt_fifo[$];
    logic [`CONV_ACC_W-1:0] out_fifo[$];
    logic [`CONV_DATA_W-1:0] if_samples[$];
    logic [`CONV_DATA_W-1:0] filt_samples[$];
    logic [`CONV_ACC_W-1:0] exp_sums[$];
    logic [`CONV_ACC_W-1:0] saved_sums[$];

    integer seed = 33712;
    int     err_count = 0;
    int     test_count = 0;
    int     failed_tests = 0;
    logic   empty_bursts = 1'b0;
    logic   full_bursts = 1'b0;
    logic   full_level = 1'b0;
    int     full_stretch = 0;
    logic   if_gap;
    logic   filt_gap;

    clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(5)) i_clk_gen (.clk(clk), .rst(rst));

    conv_pe_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .apb_req        (apb_req),
        .prdata         (prdata),
        .pready         (pready),
        .pslverr        (pslverr),
        .if_buf_empty   (if_buf_empty),
        .if_buf_data    (if_buf_data),
        .if_buf_read    (if_buf_read),
        .filt_buf_empty (filt_buf_empty),
        .filt_buf_data  (filt_buf_data),
        .filt_buf_read  (filt_buf_read),
        .out_buf_full   (out_buf_full),
        .out_buf_write  (out_buf_write),
        .out_buf_data   (out_buf_data)
    );

    // FWFT input buffer models show the head word while not empty
    always @(posedge clk) begin
        if (if_buf_read && if_fifo.size() > 0) begin
            void'(if_fifo.pop_front());
        end
        if_gap = empty_bursts && ({$random(seed)} % 3 == 0);
        if_buf_empty <= (if_fifo.size() == 0) || if_gap;
        if (if_fifo.size() > 0) begin
            if_buf_data <= if_fifo[0];
        end else begin
            if_buf_data <= '0;
        end
    end

    always @(posedge clk) begin
        if (filt_buf_read && filt_fifo.size() > 0) begin
            void'(filt_fifo.pop_front());
        end
        filt_gap = empty_bursts && ({$random(seed)} % 3 == 0);
        filt_buf_empty <= (filt_fifo.size() == 0) || filt_gap;
        if (filt_fifo.size() > 0) begin
            filt_buf_data <= filt_fifo[0];
        end else begin
            filt_buf_data <= '0;
        end
    end

    // Output buffer with full asserted for random stretches
    always @(posedge clk) begin
        assert (!(out_buf_write && out_buf_full)) else begin
            $display("%0t: output buffer written while full", $time);
            err_count++;
        end
        if (out_buf_write) begin
            out_fifo.push_back(out_buf_data.value);
        end
        if (!full_bursts) begin
            full_level = 1'b0;
            full_stretch = 0;
        end else if (full_stretch == 0) begin
            full_level = ~full_level;
            full_stretch = 1 + {$random(seed)} % 6;
        end else begin
            full_stretch--;
        end
        out_buf_full <= full_level;
    end

    task automatic timeout_abort(input string what);
        $display("Timeout: %s", what);
        $display("Errors found");
        $finish;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
        assert (got === exp) else begin
            $display("[ERROR] %0t %s expected 0x%0h got 0x%0h", $time, name, exp, got);
            err_count++;
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b1, paddr: addr, pwdata: data};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_value("pready", 1, pready);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge clk);
        apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: 1'b0, paddr: addr, pwdata: '0};
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);
        data = prdata;
        check_value("pready", 1, pready);
        @(posedge clk);
        apb_req <= '0;
    endtask

    task automatic wait_done();
        logic [31:0] rd;
        pe_status_t  st;
        int          polls;
        polls = 0;
        st = '0;
        while (!st.done && polls < DONE_POLLS) begin
            apb_read(REG_STATUS, rd);
            st = pe_status_t'(rd[8:0]);
            polls++;
        end
        if (!st.done) begin
            timeout_abort("STATUS done bit never went high");
        end
    endtask

    task automatic wait_outputs(input int n);
        int cycles;
        cycles = 0;
        while (out_fifo.size() < n && cycles < OUT_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (out_fifo.size() < n) begin
            timeout_abort("output buffer did not receive every partial sum");
        end
    endtask

    // Sum over taps of filter[j] * IF[k * stride + j]
    task automatic build_expected(input int flen, input int stride);
        int                     n_if;
        int                     n_out;
        logic [`CONV_ACC_W-1:0] acc;
        exp_sums.delete();
        n_if = if_samples.size();
        n_out = (n_if >= flen) ? (n_if - flen) / stride + 1 : 0;
        for (int k = 0; k < n_out; k++) begin
            acc = '0;
            for (int j = 0; j < flen; j++) begin
                acc = acc + 24'(filt_samples[j]) * 24'(if_samples[k * stride + j]);
            end
            exp_sums.push_back(acc);
        end
    endtask

    task automatic random_samples(input int n_if, input int n_filt);
        if_samples.delete();
        filt_samples.delete();
        for (int i = 0; i < n_if; i++) begin
            if_samples.push_back(8'($random(seed)));
        end
        for (int j = 0; j < n_filt; j++) begin
            filt_samples.push_back(8'($random(seed)));
        end
    endtask

    task automatic unit_stride_samples();
        if_samples = '{8'd3, 8'd17, 8'd250, 8'd0, 8'd96, 8'd41, 8'd128, 8'd7, 8'd255, 8'd64};
        filt_samples = '{8'd2, 8'd255, 8'd19};
    endtask

    task automatic run_case(input int flen, input int stride, input logic busy_write);
        logic        err;
        logic [31:0] rd;
        pe_status_t  st;
        build_expected(flen, stride);
        out_fifo.delete();
        for (int i = 0; i < if_samples.size(); i++) begin
            if_fifo.push_back('{last: (i == if_samples.size() - 1), data: if_samples[i]});
        end
        for (int j = 0; j < flen; j++) begin
            filt_fifo.push_back('{data: filt_samples[j]});
        end
        apb_write(REG_FILT_LEN, flen, err);
        check_value("pslverr", 0, err);
        apb_write(REG_STRIDE, stride, err);
        check_value("pslverr", 0, err);
        apb_write(REG_CTRL, 32'h1, err);
        check_value("pslverr", 0, err);
        if (busy_write) begin
            apb_write(REG_FILT_LEN, flen + 1, err);
            check_value("pslverr", 1, err);
            apb_read(REG_FILT_LEN, rd);
            check_value("filt_len", flen, rd);
        end
        wait_done();
        // Let a sum still held by the writer drain
        full_bursts = 1'b0;
        wait_outputs(exp_sums.size());
        apb_read(REG_STATUS, rd);
        st = pe_status_t'(rd[8:0]);
        check_value("status.busy", 0, st.busy);
        check_value("status.out_count", exp_sums.size(), st.out_count);
        check_value("output count", exp_sums.size(), out_fifo.size());
        for (int i = 0; i < exp_sums.size() && i < out_fifo.size(); i++) begin
            check_value($sformatf("out_buf_data[%0d]", i), exp_sums[i], out_fifo[i]);
        end
    endtask

    task automatic end_test(input string name, input int errs_before);
        test_count++;
        if (err_count == errs_before) begin
            $display("%s: pass", name);
        end else begin
            failed_tests++;
            $display("%s: FAIL with %0d mismatches", name, err_count - errs_before);
        end
    endtask

    task automatic test_apb_regs();
        int          errs;
        logic        err;
        logic [31:0] rd;
        pe_status_t  st;
        errs = err_count;
        apb_read(REG_STATUS, rd);
        st = pe_status_t'(rd[8:0]);
        check_value("status.busy", 0, st.busy);
        check_value("status.done", 0, st.done);
        apb_write(REG_FILT_LEN, 32'd9, err);
        check_value("pslverr", 0, err);
        apb_write(REG_STRIDE, 32'd5, err);
        check_value("pslverr", 0, err);
        apb_read(REG_FILT_LEN, rd);
        check_value("filt_len", 9, rd);
        apb_read(REG_STRIDE, rd);
        check_value("stride", 5, rd);
        apb_write(REG_STATUS, 32'h1, err);
        check_value("pslverr", 1, err);
        apb_write(4'h6, 32'h3, err);
        check_value("pslverr", 1, err);
        apb_read(REG_FILT_LEN, rd);
        check_value("filt_len", 9, rd);
        end_test("test 1 APB registers", errs);
    endtask

    task automatic test_unit_stride();
        int errs;
        errs = err_count;
        unit_stride_samples();
        run_case(3, 1, 1'b0);
        check_value("output count", 8, out_fifo.size());
        saved_sums = out_fifo;
        end_test("test 2 unit stride", errs);
    endtask

    task automatic test_stride_full_filter();
        int errs;
        errs = err_count;
        random_samples(40, 16);
        run_case(16, 3, 1'b0);
        check_value("output count", 9, out_fifo.size());
        end_test("test 3 stride 3 with 16 taps", errs);
    endtask

    task automatic test_back_pressure();
        int errs;
        errs = err_count;
        random_samples(30, 4);
        full_bursts = 1'b1;
        run_case(4, 2, 1'b0);
        end_test("test 4 output back-pressure", errs);
    endtask

    task automatic test_bursty_input();
        int errs;
        errs = err_count;
        unit_stride_samples();
        empty_bursts = 1'b1;
        run_case(3, 1, 1'b0);
        empty_bursts = 1'b0;
        check_value("output count vs test 2", saved_sums.size(), out_fifo.size());
        for (int i = 0; i < saved_sums.size() && i < out_fifo.size(); i++) begin
            check_value($sformatf("out_buf_data[%0d]", i), saved_sums[i], out_fifo[i]);
        end
        end_test("test 5 bursty input buffers", errs);
    endtask

    task automatic test_busy_cfg_write();
        int errs;
        errs = err_count;
        random_samples(10, 3);
        run_case(3, 1, 1'b1);
        end_test("test 6 config write while busy", errs);
    endtask

    initial begin
        int cycles;
        cycles = 0;
        while (rst !== 1'b0 && cycles < 20) begin
            @(posedge clk);
            cycles++;
        end
        if (rst !== 1'b0) begin
            timeout_abort("reset was never released");
        end
        test_apb_regs();
        test_unit_stride();
        test_stride_full_filter();
        test_back_pressure();
        test_bursty_input();
        test_busy_cfg_write();
        $display("Tests run: %0d, tests failed: %0d, mismatches: %0d",
                 test_count, failed_tests, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- conv_pe_top.f
+incdir+design
design/conv_pe_data_pkg.sv
design/conv_pe_ctrl_pkg.sv
design/conv_pe_regs.sv
design/if_loader.sv
design/filt_loader.sv
design/mac_datapath.sv
design/psum_writer.sv
design/conv_pe_top.sv
sim/clk_gen.sv
sim/tb_conv_pe.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_conv_pe
FILELIST  ?= conv_pe_top.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST)) design/conv_pe_config.svh
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not the simulator exit code
run: compile
	-./$(BIN) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		{ echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
